//--- gfx_regs.sv
`timescale 1ns/100ps

module gfx_regs import tile_gfx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       reg_wr,
    input  reg_sel_t   reg_sel,
    input  logic [8:0] reg_wdata,
    output logic [8:0] scrx,
    output logic [7:0] scry,
    output logic       bg_enable
);

    // Background shown by default after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            scrx      <= 9'd0;
            scry      <= 8'd0;
            bg_enable <= 1'b1;
        end else if (reg_wr) begin
            case (reg_sel)
                REG_SCRX: scrx      <= reg_wdata;
                REG_SCRY: scry      <= reg_wdata[7:0];
                REG_CTRL: bg_enable <= reg_wdata[0];
                default: begin
                    // Unused select code leaves all registers unchanged
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Write strobe must come with a known select
    a_sel_known: assert property (
        @(posedge clk) disable iff (reset)
        reg_wr |-> !$isunknown(reg_sel)
    ) else $error("gfx_regs: reg_sel unknown during write");

endmodule

//--- line_buffer.sv
`timescale 1ns/100ps
`include "tile_gfx_params.svh"

module line_buffer (
    input  logic              clk,
    input  logic              bank,
    input  logic [`LB_AW-1:0] wr_idx,
    input  logic [`PIX_W-1:0] wr_data,
    input  logic              wren,
    input  logic [`LB_AW-1:0] rd_idx,
    output logic [`PIX_W-1:0] rd_data
);

    localparam int DEPTH = 2 * (1 << `LB_AW);

    // Both banks in one array with bank select as the top address bit
    logic [`PIX_W-1:0] mem [0:DEPTH-1];

    logic [`LB_AW:0] wr_addr;
    logic [`LB_AW:0] rd_addr;

    assign wr_addr = {bank, wr_idx};
    assign rd_addr = {~bank, rd_idx};

    always_ff @(posedge clk) begin
        if (wren)
            mem[wr_addr] <= wr_data;
    end

    // Video side reads the bank not being rendered
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- line_fetch.sv
`timescale 1ns/100ps
`include "tile_gfx_params.svh"

module line_fetch import tile_gfx_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [7:0]         vline,
    input  logic [8:0]         scrx,
    input  logic [7:0]         scry,
    output logic [`VRAM_AW-1:0] vaddr,
    input  logic [`VRAM_DW-1:0] vdata,
    output logic               load,
    output logic [31:0]        pattern,
    output logic               hflip,
    output logic [1:0]         palette,
    output logic [`LB_AW-1:0]  start_idx,
    input  logic               sh_busy,
    input  logic               sh_last,
    output logic               bank,
    output logic               done
);

    fetch_state_t state, state_next;

    logic [`VRAM_AW-1:0] vaddr_r;
    logic [4:0]          col, col_next;
    logic [5:0]          col_cnt, col_cnt_next;
    logic [`LB_AW-1:0]   idx_r, idx_next;
    logic [15:0]         map_r;
    logic [15:0]         pat_hi_r, pat_hi_next;
    logic                bank_r;

    ////////////////////
    // Address terms
    ////////////////////

    logic [7:0]  bmline;
    logic [7:0]  tline;
    logic [4:0]  row;
    logic [15:0] map_entry;
    logic [8:0]  tile_idx;
    logic        tile_vflip;
    logic [2:0]  pat_row;

    assign bmline = vline - 8'(`FIRST_VLINE);
    assign tline  = bmline + scry;
    assign row    = tline[7:3];

    // Map entry is on vdata in FETCH_MAP and held in map_r afterwards
    assign map_entry  = (state == FETCH_MAP) ? vdata : map_r;
    assign tile_idx   = map_entry[8:0];
    assign tile_vflip = map_entry[10];
    assign pat_row    = tile_vflip ? ~tline[2:0] : tline[2:0];

    ////////////////////
    // Sequencer
    ////////////////////

    always_comb begin
        state_next   = state;
        vaddr        = vaddr_r;
        col_next     = col;
        col_cnt_next = col_cnt;
        idx_next     = idx_r;
        pat_hi_next  = pat_hi_r;
        load         = 1'b0;

        if (start) begin
            col_next     = scrx[7:3];
            col_cnt_next = 6'd0;
            idx_next     = {`LB_AW{1'b0}} - `LB_AW'(scrx[2:0]);
            vaddr        = {3'b000, row, col_next};
            state_next   = FETCH_MAP;
        end else begin
            case (state)
                FETCH_MAP: begin
                    vaddr        = {tile_idx, pat_row, 1'b0};
                    col_next     = col + 5'd1;
                    col_cnt_next = col_cnt + 6'd1;
                    state_next   = FETCH_PAT1;
                end
                FETCH_PAT1: begin
                    // Word 0 gives bytes 0 and 1
                    pat_hi_next = {vdata[7:0], vdata[15:8]};
                    vaddr       = {vaddr_r[`VRAM_AW-1:1], 1'b1};
                    state_next  = FETCH_PAT2;
                end
                FETCH_PAT2: begin
                    // Word 1 stays on vdata until the shifter accepts it
                    if (!sh_busy || sh_last) begin
                        load       = 1'b1;
                        idx_next   = idx_r + `LB_AW'(8);
                        vaddr      = {3'b000, row, col};
                        state_next = (col_cnt == 6'(`LINE_COLS)) ? FETCH_DONE : FETCH_MAP;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH_DONE;
            col     <= 5'd0;
            col_cnt <= 6'd0;
            idx_r   <= {`LB_AW{1'b0}};
            bank_r  <= 1'b0;
        end else begin
            state   <= state_next;
            col     <= col_next;
            col_cnt <= col_cnt_next;
            idx_r   <= idx_next;
            if (start)
                bank_r <= ~bank_r;
        end
    end

    always_ff @(posedge clk) begin
        vaddr_r  <= vaddr;
        pat_hi_r <= pat_hi_next;
        if (state == FETCH_MAP)
            map_r <= vdata;
    end

    // Shifter hand-off
    assign pattern   = {pat_hi_r, vdata[7:0], vdata[15:8]};
    assign hflip     = map_r[9];
    assign palette   = map_r[13:12];
    assign start_idx = idx_r;
    assign bank      = bank_r;
    assign done      = (state == FETCH_DONE);

    ////////////////////
    // Checks
    ////////////////////

    a_load_paced: assert property (
        @(posedge clk) disable iff (reset)
        (load && sh_busy) |-> sh_last
    ) else $error("line_fetch: load while shifter busy in %s", state.name());

    a_done_holds: assert property (
        @(posedge clk) disable iff (reset)
        (state == FETCH_DONE && !start) |=> (state == FETCH_DONE)
    ) else $error("line_fetch: left FETCH_DONE without start");

endmodule

//--- pixel_shifter.sv
`timescale 1ns/100ps
`include "tile_gfx_params.svh"

module pixel_shifter (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  logic [31:0]       pattern,
    input  logic              hflip,
    input  logic [1:0]        palette,
    input  logic [`LB_AW-1:0] start_idx,
    input  logic              bg_enable,
    output logic [`LB_AW-1:0] wridx,
    output logic [`PIX_W-1:0] wrdata,
    output logic              wren,
    output logic              busy,
    output logic              last_pixel
);

    logic [31:0]       shreg;
    logic              flip_r;
    logic [1:0]        pal_r;
    logic [`LB_AW-1:0] idx_r;
    logic [2:0]        cnt;
    logic              active;
    logic [3:0]        nibble;

    // Normal order takes the top nibble and flipped order the bottom one
    assign nibble = flip_r ? shreg[3:0] : shreg[31:28];

    assign wren       = active;
    assign busy       = active;
    assign last_pixel = active && (cnt == 3'd7);
    assign wridx      = idx_r;
    assign wrdata     = bg_enable ? {pal_r, nibble} : {`PIX_W{1'b0}};

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            cnt    <= 3'd0;
        end else if (load) begin
            active <= 1'b1;
            cnt    <= 3'd0;
        end else if (active) begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'd7)
                active <= 1'b0;
        end
    end

    // Tile payload with one nibble consumed per write
    always_ff @(posedge clk) begin
        if (load) begin
            shreg  <= pattern;
            flip_r <= hflip;
            pal_r  <= palette;
            idx_r  <= start_idx;
        end else if (active) begin
            shreg <= flip_r ? (shreg >> 4) : (shreg << 4);
            idx_r <= idx_r + `LB_AW'(1);
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tile_gfx.f --top-module tb_tile_gfx -o tb_tile_gfx

./obj_dir/tb_tile_gfx | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tb_tile_gfx.sv
`timescale 1ns/100ps
`include "tile_gfx_params.svh"

module tb_tile_gfx import tile_gfx_pkg::*; ();

    localparam int NUM_TESTS = 8;
    localparam int IDLE_TIMEOUT = 4000;

    logic                clk = 1'b0;
    logic                reset;
    logic                reg_wr;
    reg_sel_t            reg_sel;
    logic [8:0]          reg_wdata;
    logic                start;
    logic [7:0]          vline;
    logic [`VRAM_AW-1:0] vaddr;
    logic [`VRAM_DW-1:0] vdata = '0;
    logic [`LB_AW-1:0]   rd_idx;
    logic [`PIX_W-1:0]   rd_data;
    logic                busy;

    logic [`VRAM_DW-1:0] vram [0:(1 << `VRAM_AW)-1];

    // Test table with one row per line rendered
    string      test_name [0:NUM_TESTS-1] = '{"unscrolled", "fine_x3", "coarse_x13",
        "wrap_x261", "vscroll_wrap", "flip_palette", "bg_disabled", "bg_reenabled"};
    logic [8:0] tab_scrx [0:NUM_TESTS-1] = '{9'd0, 9'd3, 9'd13, 9'd261, 9'd0, 9'd0, 9'd0, 9'd5};
    logic [7:0] tab_scry [0:NUM_TESTS-1] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd250, 8'd0, 8'd0, 8'd0};
    logic [7:0] tab_vline [0:NUM_TESTS-1] = '{8'd15, 8'd15, 8'd60, 8'd200, 8'd30, 8'd57,
        8'd57, 8'd57};
    logic       tab_bg [0:NUM_TESTS-1] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    tile_gfx uut (
        .clk(clk), .reset(reset), .reg_wr(reg_wr), .reg_sel(reg_sel),
        .reg_wdata(reg_wdata), .start(start), .vline(vline), .vaddr(vaddr),
        .vdata(vdata), .rd_idx(rd_idx), .rd_data(rd_data), .busy(busy)
    );

    always #50 clk = ~clk;

    // VRAM model with a synchronous read port
    always @(posedge clk) begin
        vdata <= vram[vaddr];
    end

    ////////////////////
    // Models
    ////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [5:0] expected_pixel(input int idx, input logic [8:0] sx,
                                                  input logic [7:0] sy, input logic [7:0] vl,
                                                  input logic bg);
        int          p;
        int          t;
        int          k;
        int          kk;
        int          b;
        logic [7:0]  tl;
        logic [4:0]  col;
        logic [15:0] entry;
        logic [2:0]  prow;
        logic [15:0] word;
        logic [7:0]  byt;
        logic [3:0]  nib;
        // Screen index back to tile number and pixel within the tile
        p = idx + int'(sx[2:0]);
        t = p / 8;
        k = p % 8;
        tl = vl - 8'(`FIRST_VLINE) + sy;
        col = 5'((int'(sx) / 8 + t) % 32);
        entry = vram[{3'b000, tl[7:3], col}];
        prow = entry[10] ? 3'd7 - tl[2:0] : tl[2:0];
        kk = entry[9] ? 7 - k : k;
        b = kk / 2;
        word = vram[{entry[8:0], prow, (b >= 2)}];
        byt = (b % 2 == 1) ? word[15:8] : word[7:0];
        nib = (kk % 2 == 0) ? byt[7:4] : byt[3:0];
        return bg ? {entry[13:12], nib} : 6'd0;
    endfunction

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic write_reg(input reg_sel_t sel, input logic [8:0] data);
        @(posedge clk);
        #1;
        reg_wr = 1'b1;
        reg_sel = sel;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_idle(output bit ok);
        int cycles;
        ok = 1'b0;
        for (cycles = 0; cycles < IDLE_TIMEOUT && !ok; cycles++) begin
            @(posedge clk);
            #1;
            if (!busy)
                ok = 1'b1;
        end
    endtask

    // Reads the finished bank while the next line fills the other one
    task automatic check_line(input string name, input logic [8:0] sx, input logic [7:0] sy,
                              input logic [7:0] vl, input logic bg, output int mism);
        int         i;
        logic [5:0] exp;
        mism = 0;
        rd_idx = 9'd0;
        for (i = 0; i < `LINE_PIXELS; i++) begin
            @(posedge clk);
            #1;
            exp = expected_pixel(i, sx, sy, vl, bg);
            assert (rd_data === exp) else begin
                $display("ERR %s idx %0d expected %h actual %h", name, i, exp, rd_data);
                mism++;
            end
            rd_idx = 9'(i + 1);
        end
    endtask

    initial begin
        int          t;
        int          a;
        int          mism;
        int          mism_after;
        int          failed;
        int          total_mism;
        bit          ok;
        bit          hung;
        logic [15:0] lfsr;
        logic [15:0] word;
        logic [12:0] addr;
        reset = 1'b1;
        reg_wr = 1'b0;
        reg_sel = REG_SCRX;
        reg_wdata = 9'd0;
        start = 1'b0;
        vline = 8'd0;
        rd_idx = 9'd0;
        failed = 0;
        total_mism = 0;
        hung = 1'b0;
        word = 16'd0;

        // Random VRAM contents with one LFSR step per bit
        lfsr = 16'd54;
        for (a = 0; a < (1 << `VRAM_AW); a++) begin
            repeat (16) begin
                lfsr = lfsr_step(lfsr);
                word = {word[14:0], lfsr[0]};
            end
            vram[13'(a)] = word;
        end
        // Map row 5 gets both flips on even columns and hflip alone on odd ones
        for (a = 0; a < 32; a++) begin
            addr = 13'(5 * 32 + a);
            vram[addr] = vram[addr] | ((a % 2 == 0) ? 16'h0600 : 16'h0200);
        end

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        for (t = 0; t < NUM_TESTS && !hung; t++) begin
            vline = tab_vline[t];
            write_reg(REG_SCRX, tab_scrx[t]);
            write_reg(REG_SCRY, {1'b0, tab_scry[t]});
            write_reg(REG_CTRL, {8'd0, tab_bg[t]});
            pulse_start();
            wait_idle(ok);
            mism = 0;
            if (ok) begin
                // Bank swap while a different line renders behind the read
                vline = tab_vline[t] + 8'd8;
                pulse_start();
                check_line(test_name[t], tab_scrx[t], tab_scry[t], tab_vline[t], tab_bg[t],
                           mism);
                wait_idle(ok);
                if (ok) begin
                    // Finished bank stays intact once the other line is complete
                    check_line(test_name[t], tab_scrx[t], tab_scry[t], tab_vline[t],
                               tab_bg[t], mism_after);
                    mism += mism_after;
                end
            end
            if (!ok) begin
                $display("Busy did not fall within %0d cycles in test %s", IDLE_TIMEOUT,
                         test_name[t]);
                hung = 1'b1;
                failed++;
            end else begin
                $display("test %s finished with %0d mismatches", test_name[t], mism);
                total_mism += mism;
                if (mism != 0)
                    failed++;
            end
        end

        $display("tests run %0d, tests failed %0d, pixel mismatches %0d", t, failed,
                 total_mism);
        if (hung || failed != 0)
            $display("Errors found");
        else
            $display("No errors");
        $finish;
    end

endmodule

//--- tile_gfx.f
+incdir+.
tile_gfx_pkg.sv
gfx_regs.sv
line_fetch.sv
pixel_shifter.sv
line_buffer.sv
tile_gfx.sv
tb_tile_gfx.sv

//--- tile_gfx.sv
`timescale 1ns/100ps
`include "tile_gfx_params.svh"

module tile_gfx import tile_gfx_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                reg_wr,
    input  reg_sel_t            reg_sel,
    input  logic [8:0]          reg_wdata,
    input  logic                start,
    input  logic [7:0]          vline,
    output logic [`VRAM_AW-1:0] vaddr,
    input  logic [`VRAM_DW-1:0] vdata,
    input  logic [`LB_AW-1:0]   rd_idx,
    output logic [`PIX_W-1:0]   rd_data,
    output logic                busy
);

    logic [8:0]        scrx;
    logic [7:0]        scry;
    logic              bg_enable;
    logic              load;
    logic [31:0]       pattern;
    logic              hflip;
    logic [1:0]        palette;
    logic [`LB_AW-1:0] start_idx;
    logic              sh_busy;
    logic              sh_last;
    logic              bank;
    logic              done;
    logic [`LB_AW-1:0] wridx;
    logic [`PIX_W-1:0] wrdata;
    logic              wren;

    ////////////////////
    // Registers and fetch
    ////////////////////

    gfx_regs u_regs (
        .clk(clk), .reset(reset),
        .reg_wr(reg_wr), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .scrx(scrx), .scry(scry), .bg_enable(bg_enable)
    );

    line_fetch u_fetch (
        .clk(clk), .reset(reset), .start(start), .vline(vline),
        .scrx(scrx), .scry(scry), .vaddr(vaddr), .vdata(vdata),
        .load(load), .pattern(pattern), .hflip(hflip), .palette(palette),
        .start_idx(start_idx), .sh_busy(sh_busy), .sh_last(sh_last),
        .bank(bank), .done(done)
    );

    ////////////////////
    // Pixels
    ////////////////////

    pixel_shifter u_shifter (
        .clk(clk), .reset(reset), .load(load), .pattern(pattern),
        .hflip(hflip), .palette(palette), .start_idx(start_idx),
        .bg_enable(bg_enable), .wridx(wridx), .wrdata(wrdata), .wren(wren),
        .busy(sh_busy), .last_pixel(sh_last)
    );

    line_buffer u_linebuf (
        .clk(clk), .bank(bank), .wr_idx(wridx), .wr_data(wrdata), .wren(wren),
        .rd_idx(rd_idx), .rd_data(rd_data)
    );

    // Line finished once fetch is done and the last tile is written out
    assign busy = !done || sh_busy;

endmodule

//--- tile_gfx_params.svh
`ifndef TILE_GFX_PARAMS_SVH
`define TILE_GFX_PARAMS_SVH

// Video RAM port
`define VRAM_AW 13
`define VRAM_DW 16

// Line buffer index and pixel format (palette and colour)
`define LB_AW 9
`define PIX_W 6

// Line geometry
`define LINE_PIXELS 320
`define LINE_COLS 41

// First video line of the bitmap area
`define FIRST_VLINE 15

`endif

//--- tile_gfx_pkg.sv
package tile_gfx_pkg;

    // Fetch sequencer states with one map read and two pattern reads per column
    typedef enum logic [1:0] {
        FETCH_MAP  = 2'd0,
        FETCH_PAT1 = 2'd1,
        FETCH_PAT2 = 2'd2,
        FETCH_DONE = 2'd3
    } fetch_state_t;

    // Register select opcodes on the CPU port
    typedef enum logic [1:0] {
        REG_SCRX = 2'd0,
        REG_SCRY = 2'd1,
        REG_CTRL = 2'd2
    } reg_sel_t;

endpackage
